/* sources.f */
rtl/warp_types_pkg.sv
rtl/isa_pkg.sv
rtl/instr_decoder.sv
rtl/scalar_alu.sv
rtl/scalar_reg_file.sv
rtl/warp_sequencer.sv
rtl/scalar_warp_core.sv
dv/scalar_warp_core_asserts.sv
dv/tb_scalar_warp_core.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_scalar_warp_core -f sources.f -Mdir obj_dir -o tb_sim
	./obj_dir/tb_sim

clean:
	rm -rf obj_dir

/* dv/tb_scalar_warp_core.sv */
`timescale 1ns/10ps

module tb_scalar_warp_core
    import warp_types_pkg::*;
    import isa_pkg::*;
();

    // instruction counts per test size the timeout
    localparam int ALU_COUNT = 32;
    localparam int ZERO_COUNT = 6;
    localparam int LINK_COUNT = 5;
    localparam int PRESSURE_COUNT = 40;
    localparam int TOTAL_INSTRS = ALU_COUNT + ZERO_COUNT + LINK_COUNT + PRESSURE_COUNT;
    localparam int TIMEOUT_CYCLES = 8 * TOTAL_INSTRS + 200;
    localparam logic [31:0] LFSR_SEED = 32'h8643;
    // x^32 + x^22 + x^2 + x + 1
    localparam logic [31:0] LFSR_TAPS = 32'h80200003;

    logic      clk;
    logic      reset;
    logic      instr_valid;
    instr_t    instr;
    logic      result_credit;
    logic      instr_credit;
    logic      result_valid;
    reg_addr_t result_rd;
    data_t     result_data;
    data_t     warp_execution_mask;

    logic [31:0] lfsr_state;
    int          cycle_count;
    // reference model
    data_t       model_regs [NUM_REGS];
    pc_t         model_pc;
    // pending stimulus and expected records in program order
    instr_t      send_q [$];
    reg_addr_t   exp_rd_q [$];
    data_t       exp_data_q [$];
    // credit bookkeeping on both links
    int          prod_credits;
    int          core_credits;
    int          owed_credits;
    int          stall_left;
    logic        pressure_on;

    scalar_warp_core i_dut (
        .clk                 (clk),
        .reset               (reset),
        .instr_valid         (instr_valid),
        .instr               (instr),
        .result_credit       (result_credit),
        .instr_credit        (instr_credit),
        .result_valid        (result_valid),
        .result_rd           (result_rd),
        .result_data         (result_data),
        .warp_execution_mask (warp_execution_mask)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        if (reset) begin
            cycle_count <= 0;
        end else begin
            cycle_count <= cycle_count + 1;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("timeout: results stopped arriving after %0d cycles", cycle_count);
                $display("Verification failed");
                $fatal(1, "simulation timeout");
            end
        end
    end

    task automatic check_equal(logic [31:0] actual, logic [31:0] expected, string what);
        if (actual !== expected) begin
            $display("[ERROR] time %0t: %s is %h, expected %h", $time, what, actual, expected);
            $display("Verification failed");
            $fatal(1, "mismatch on %s", what);
        end
    endtask

    task automatic abort_run(string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1, "%s", why);
    endtask

    // galois step returning the bit shifted out
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) lfsr_state = lfsr_state ^ LFSR_TAPS;
        return out_bit;
    endfunction

    function automatic logic [31:0] random_bits(int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            value = {value[30:0], next_random_bit()};
        end
        return value;
    endfunction

    function automatic instr_t encode(opcode_t op, reg_addr_t rd, reg_addr_t rs1,
                                      reg_addr_t rs2, logic [12:0] imm);
        return {op, rd, rs1, rs2, imm};
    endfunction

    // queue one instruction, predict its record and update the model
    task automatic issue(instr_t word);
        logic [3:0] op;
        reg_addr_t  rd;
        data_t      a;
        data_t      b;
        data_t      imm;
        data_t      value;
        logic       writes;
        op = word[OPCODE_MSB:OPCODE_LSB];
        rd = word[RD_MSB:RD_LSB];
        a = model_regs[word[RS1_MSB:RS1_LSB]];
        b = model_regs[word[RS2_MSB:RS2_LSB]];
        imm = data_t'(word[IMM_MSB:IMM_LSB]);
        // two's complement immediate
        if (word[IMM_MSB]) imm = imm - (data_t'(1) << IMM_WIDTH);
        writes = 1'b1;
        case (op)
            OP_ADD:  value = a + b;
            OP_SUB:  value = a - b;
            OP_AND:  value = a & b;
            OP_OR:   value = a | b;
            OP_XOR:  value = a ^ b;
            OP_SLL:  value = a << b[4:0];
            OP_SRL:  value = a >> b[4:0];
            OP_ADDI: value = a + imm;
            OP_LI:   value = imm;
            OP_LINK: value = data_t'(model_pc) + 32'd1;
            default: begin
                // nop and unknown codes report r0 with zero
                rd = 5'd0;
                value = '0;
                writes = 1'b0;
            end
        endcase
        // r0 stays zero in the model too
        if (writes && rd != 5'd0) model_regs[rd] = value;
        model_pc = model_pc + 8'd1;
        send_q.push_back(word);
        exp_rd_q.push_back(rd);
        exp_data_q.push_back(value);
    endtask

    // one cycle of sampling at the falling edge and then driving
    task automatic step();
        logic gap;
        @(negedge clk);
        if (instr_credit) begin
            prod_credits++;
            if (prod_credits > INSTR_CREDITS) abort_run("instruction credit returned twice");
        end
        if (result_valid) begin
            if (core_credits == 0) abort_run("result record sent with no result credit");
            if (exp_rd_q.size() == 0) abort_run("result record with no instruction pending");
            check_equal(32'(result_rd), 32'(exp_rd_q.pop_front()), "result_rd");
            check_equal(result_data, exp_data_q.pop_front(), "result_data");
            core_credits--;
            owed_credits++;
        end
        // producer skips cycles at random under back-pressure
        gap = pressure_on ? next_random_bit() : 1'b0;
        instr_valid = 1'b0;
        if (send_q.size() != 0 && prod_credits > 0 && !gap) begin
            instr_valid = 1'b1;
            instr = send_q.pop_front();
            prod_credits--;
        end
        // consumer withholds credits for random stretches
        result_credit = 1'b0;
        if (stall_left > 0) begin
            stall_left--;
        end else if (owed_credits > 0) begin
            if (pressure_on && next_random_bit()) begin
                stall_left = int'(random_bits(2));
            end else begin
                result_credit = 1'b1;
                owed_credits--;
                core_credits++;
            end
        end
    endtask

    // until every record is back and every credit returned
    task automatic run_program();
        while (send_q.size() != 0 || exp_rd_q.size() != 0 || owed_credits != 0) begin
            step();
        end
        @(negedge clk);
        instr_valid = 1'b0;
        result_credit = 1'b0;
    endtask

    task automatic reset_is_idle();
        check_equal(warp_execution_mask, '1, "mask after reset");
        for (int i = 0; i < 8; i++) begin
            @(negedge clk);
            check_equal(32'(result_valid), 32'd0, "result_valid while idle");
            check_equal(32'(instr_credit), 32'd0, "instr_credit while idle");
        end
    endtask

    task automatic alu_and_immediates();
        // r1..r8 from random immediates
        for (int r = 1; r <= 8; r++) begin
            issue(encode(OP_LI, reg_addr_t'(r), 5'd0, 5'd0, 13'(random_bits(13))));
        end
        // add through addi in turn on r1..r8 so neighbours depend on each other
        for (int i = 0; i < ALU_COUNT - 8; i++) begin
            issue(encode(opcode_t'(1 + i % 8), reg_addr_t'(random_bits(3) + 1),
                         reg_addr_t'(random_bits(3) + 1), reg_addr_t'(random_bits(3) + 1),
                         13'(random_bits(13))));
        end
        run_program();
    endtask

    task automatic zero_register();
        // writes to r0 still report their value
        issue(encode(OP_LI, 5'd0, 5'd0, 5'd0, 13'h0abc));
        issue(encode(OP_ADDI, 5'd0, 5'd1, 5'd0, 13'h0055));
        issue(encode(OP_ADD, 5'd9, 5'd0, 5'd0, 13'd0));
        issue(encode(OP_OR, 5'd10, 5'd0, 5'd2, 13'd0));
        // junk fields on a nop and an unused opcode
        issue(encode(OP_NOP, 5'd7, 5'd3, 5'd4, 13'h1fff));
        issue(encode(opcode_t'(4'hf), 5'd5, 5'd1, 5'd2, 13'd0));
        run_program();
    endtask

    task automatic link_and_mask();
        issue(encode(OP_LINK, 5'd12, 5'd0, 5'd0, 13'd0));
        issue(encode(OP_LI, 5'd31, 5'd0, 5'd0, 13'h1234));
        run_program();
        check_equal(warp_execution_mask, model_regs[EXEC_MASK_REG], "mask after li r31");
        issue(encode(OP_XOR, 5'd31, 5'd1, 5'd2, 13'd0));
        issue(encode(OP_LINK, 5'd13, 5'd0, 5'd0, 13'd0));
        // sum of both link values
        issue(encode(OP_ADD, 5'd14, 5'd12, 5'd13, 13'd0));
        run_program();
        check_equal(warp_execution_mask, model_regs[EXEC_MASK_REG], "mask after xor r31");
    endtask

    task automatic back_pressure_ordering();
        pressure_on = 1'b1;
        // any opcode including the unused ones
        for (int i = 0; i < PRESSURE_COUNT; i++) begin
            issue(encode(opcode_t'(random_bits(4)), reg_addr_t'(random_bits(5)),
                         reg_addr_t'(random_bits(5)), reg_addr_t'(random_bits(5)),
                         13'(random_bits(13))));
        end
        run_program();
        pressure_on = 1'b0;
        check_equal(warp_execution_mask, model_regs[EXEC_MASK_REG], "mask after random run");
    endtask

    initial begin
        lfsr_state = LFSR_SEED;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        result_credit = 1'b0;
        pressure_on = 1'b0;
        prod_credits = INSTR_CREDITS;
        core_credits = RESULT_CREDITS;
        owed_credits = 0;
        stall_left = 0;
        model_pc = '0;
        for (int r = 0; r < NUM_REGS; r++) begin
            model_regs[r] = '0;
        end
        model_regs[EXEC_MASK_REG] = '1;
        // two reset edges then release on a falling edge
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        reset_is_idle();
        alu_and_immediates();
        zero_register();
        link_and_mask();
        back_pressure_ordering();
        $display("Verification passed");
        $finish;
    end

endmodule

/* dv/scalar_warp_core_asserts.sv */
`timescale 1ns/10ps

module scalar_warp_core_asserts
    import warp_types_pkg::*;
    import isa_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input logic        instr_valid,
    input logic        instr_credit,
    input logic        result_valid,
    input logic        result_credit,
    input warp_state_t warp_state
);

    // shadow counts rebuilt from the link pulses
    logic [2:0] held_credits;
    logic [2:0] buffered;

    always_ff @(posedge clk) begin
        if (reset) begin
            held_credits <= 3'(RESULT_CREDITS);
            buffered <= '0;
        end else begin
            held_credits <= held_credits + 3'(result_credit) - 3'(result_valid);
            buffered <= buffered + 3'(instr_valid) - 3'(instr_credit);
        end
    end

    // a result spends a credit the core holds
    assert property (@(posedge clk) disable iff (reset)
        result_valid |-> (held_credits != '0))
        else $error("result_valid without a result credit");

    // a credit only comes back for a buffered entry
    assert property (@(posedge clk) disable iff (reset)
        instr_credit |-> (buffered != '0))
        else $error("instr_credit with an empty instruction buffer");

    // first cycle out of reset
    assert property (@(posedge clk)
        $fell(reset) |-> ((warp_state == WARP_IDLE) && !result_valid))
        else $error("core not idle after reset");

endmodule

bind scalar_warp_core scalar_warp_core_asserts i_asserts (
    .clk           (clk),
    .reset         (reset),
    .instr_valid   (instr_valid),
    .instr_credit  (instr_credit),
    .result_valid  (result_valid),
    .result_credit (result_credit),
    .warp_state    (warp_state)
);

/* rtl/scalar_warp_core.sv */
`timescale 1ns/10ps

module scalar_warp_core
    import warp_types_pkg::*;
    import isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      instr_valid,
    input  instr_t    instr,
    input  logic      result_credit,
    output logic      instr_credit,
    output logic      result_valid,
    output reg_addr_t result_rd,
    output data_t     result_data,
    output data_t     warp_execution_mask
);

    // current instruction and its decoded fields
    instr_t         cur_instr;
    reg_addr_t      rd_address;
    reg_addr_t      rs1_address;
    reg_addr_t      rs2_address;
    data_t          immediate;
    alu_op_t        alu_op;
    logic           use_immediate;
    logic           reg_write_enable;
    reg_input_mux_t reg_input_mux;

    // operands, alu result, writeback value
    data_t          rs1;
    data_t          rs2;
    data_t          alu_out;
    data_t          wb_data;

    // sequencer control
    warp_state_t    warp_state;
    pc_t            pc;
    logic           update_go;

    // decode
    instr_decoder i_decoder (
        .instr            (cur_instr),
        .rd_address       (rd_address),
        .rs1_address      (rs1_address),
        .rs2_address      (rs2_address),
        .immediate        (immediate),
        .alu_op           (alu_op),
        .use_immediate    (use_immediate),
        .reg_write_enable (reg_write_enable),
        .reg_input_mux    (reg_input_mux)
    );

    // execute
    scalar_alu i_alu (
        .alu_op        (alu_op),
        .operand_a     (rs1),
        .operand_b     (rs2),
        .immediate     (immediate),
        .use_immediate (use_immediate),
        .alu_out       (alu_out)
    );

    // operand read and writeback
    scalar_reg_file i_reg_file (
        .clk                 (clk),
        .reset               (reset),
        .warp_state          (warp_state),
        .update_go           (update_go),
        .reg_write_enable    (reg_write_enable),
        .reg_input_mux       (reg_input_mux),
        .immediate           (immediate),
        .rd_address          (rd_address),
        .rs1_address         (rs1_address),
        .rs2_address         (rs2_address),
        .alu_out             (alu_out),
        .pc                  (pc),
        .warp_execution_mask (warp_execution_mask),
        .rs1                 (rs1),
        .rs2                 (rs2),
        .wb_data             (wb_data)
    );

    // buffer, state machine, credits and result stream
    warp_sequencer i_sequencer (
        .clk           (clk),
        .reset         (reset),
        .instr_valid   (instr_valid),
        .instr         (instr),
        .result_credit (result_credit),
        .wb_data       (wb_data),
        .rd_address    (rd_address),
        .instr_credit  (instr_credit),
        .cur_instr     (cur_instr),
        .warp_state    (warp_state),
        .pc            (pc),
        .update_go     (update_go),
        .result_valid  (result_valid),
        .result_rd     (result_rd),
        .result_data   (result_data)
    );

endmodule

/* rtl/warp_sequencer.sv */
`timescale 1ns/10ps

module warp_sequencer
    import warp_types_pkg::*;
    import isa_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        instr_valid,
    input  instr_t      instr,
    input  logic        result_credit,
    input  data_t       wb_data,
    input  reg_addr_t   rd_address,
    output logic        instr_credit,
    output instr_t      cur_instr,
    output warp_state_t warp_state,
    output pc_t         pc,
    output logic        update_go,
    output logic        result_valid,
    output reg_addr_t   result_rd,
    output data_t       result_data
);

    // instruction buffer, sized by the producer credits
    instr_t                           buf_mem [INSTR_CREDITS];
    logic [$clog2(INSTR_CREDITS)-1:0] wr_ptr;
    logic [$clog2(INSTR_CREDITS)-1:0] rd_ptr;
    credit_t                          buf_count;
    credit_t                          result_credits;
    warp_state_t                      next_state;
    logic                             buf_pop;
    logic                             load_cur;

    // head leaves the buffer at the end of request
    // its credit goes back in the same cycle
    assign buf_pop = (warp_state == WARP_REQUEST);
    assign instr_credit = buf_pop;

    // retire only while a result credit is held
    assign update_go = (warp_state == WARP_UPDATE) && (result_credits != '0);
    assign result_valid = update_go;
    assign result_rd = rd_address;
    assign result_data = wb_data;

    always_comb begin
        next_state = warp_state;
        case (warp_state)
            WARP_IDLE: begin
                if (buf_count != '0) next_state = WARP_REQUEST;
            end
            WARP_REQUEST: next_state = WARP_UPDATE;
            WARP_UPDATE: begin
                // stall here without a credit
                if (update_go) begin
                    next_state = (buf_count != '0) ? WARP_REQUEST : WARP_IDLE;
                end
            end
            default: next_state = WARP_IDLE;
        endcase
    end

    // head becomes current on entry to request
    assign load_cur = (next_state == WARP_REQUEST) && (warp_state != WARP_REQUEST);

    always_ff @(posedge clk) begin
        if (instr_valid) buf_mem[wr_ptr] <= instr;
        if (load_cur) cur_instr <= buf_mem[rd_ptr];
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            warp_state <= WARP_IDLE;
            wr_ptr <= '0;
            rd_ptr <= '0;
            buf_count <= '0;
            result_credits <= credit_t'(RESULT_CREDITS);
            pc <= '0;
        end else begin
            warp_state <= next_state;
            wr_ptr <= wr_ptr + instr_valid;
            rd_ptr <= rd_ptr + buf_pop;
            // push and pop may land on the same edge
            buf_count <= buf_count + credit_t'(instr_valid) - credit_t'(buf_pop);
            result_credits <= result_credits + credit_t'(result_credit) - credit_t'(update_go);
            // pc counts retired instructions
            if (update_go) pc <= pc + pc_t'(1);
        end
    end

endmodule

/* rtl/scalar_reg_file.sv */
`timescale 1ns/10ps

module scalar_reg_file
    import warp_types_pkg::*;
    import isa_pkg::*;
(
    input  logic           clk,
    input  logic           reset,
    input  warp_state_t    warp_state,
    input  logic           update_go,
    input  logic           reg_write_enable,
    input  reg_input_mux_t reg_input_mux,
    input  data_t          immediate,
    input  reg_addr_t      rd_address,
    input  reg_addr_t      rs1_address,
    input  reg_addr_t      rs2_address,
    input  data_t          alu_out,
    input  pc_t            pc,
    output data_t          warp_execution_mask,
    output data_t          rs1,
    output data_t          rs2,
    output data_t          wb_data
);

    data_t registers [NUM_REGS];
    logic  write_now;

    // mask register exported as is
    assign warp_execution_mask = registers[EXEC_MASK_REG];

    // combinational reads, r0 always zero
    assign rs1 = (rs1_address == reg_addr_t'(ZERO_REG)) ? '0 : registers[rs1_address];
    assign rs2 = (rs2_address == reg_addr_t'(ZERO_REG)) ? '0 : registers[rs2_address];

    // writeback source
    always_comb begin
        case (reg_input_mux)
            ALU_OUT:   wb_data = alu_out;
            IMMEDIATE: wb_data = immediate;
            PC_PLUS_1: wb_data = data_t'(pc) + data_t'(1);
            default:   wb_data = '0;
        endcase
    end

    // write only on a retiring update, never into r0
    assign write_now = (warp_state == WARP_UPDATE) && update_go && reg_write_enable
                       && (rd_address != reg_addr_t'(ZERO_REG));

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                registers[i] <= '0;
            end
            // all threads enabled out of reset
            registers[EXEC_MASK_REG] <= '1;
        end else if (write_now) begin
            registers[rd_address] <= wb_data;
        end
    end

endmodule

/* rtl/scalar_alu.sv */
`timescale 1ns/10ps

module scalar_alu
    import warp_types_pkg::*;
    import isa_pkg::*;
(
    input  alu_op_t alu_op,
    input  data_t   operand_a,
    input  data_t   operand_b,
    input  data_t   immediate,
    input  logic    use_immediate,
    output data_t   alu_out
);

    data_t                  operand_sel;
    logic [SHAMT_WIDTH-1:0] shamt;

    // second operand, register or immediate
    assign operand_sel = use_immediate ? immediate : operand_b;

    // shift amount from the low bits only
    assign shamt = operand_sel[SHAMT_WIDTH-1:0];

    always_comb begin
        case (alu_op)
            ALU_ADD: alu_out = operand_a + operand_sel;
            ALU_SUB: alu_out = operand_a - operand_sel;
            ALU_AND: alu_out = operand_a & operand_sel;
            ALU_OR:  alu_out = operand_a | operand_sel;
            ALU_XOR: alu_out = operand_a ^ operand_sel;
            // logical shifts, zero fill
            ALU_SLL: alu_out = operand_a << shamt;
            ALU_SRL: alu_out = operand_a >> shamt;
            // unused encoding
            default: alu_out = '0;
        endcase
    end

endmodule

/* rtl/instr_decoder.sv */
`timescale 1ns/10ps

module instr_decoder
    import warp_types_pkg::*;
    import isa_pkg::*;
(
    input  instr_t         instr,
    output reg_addr_t      rd_address,
    output reg_addr_t      rs1_address,
    output reg_addr_t      rs2_address,
    output data_t          immediate,
    output alu_op_t        alu_op,
    output logic           use_immediate,
    output logic           reg_write_enable,
    output reg_input_mux_t reg_input_mux
);

    opcode_t opcode;

    // opcode field, unknown codes fall to the default arm below
    assign opcode = opcode_t'(instr[OPCODE_MSB:OPCODE_LSB]);

    // sign-extended 13-bit immediate
    assign immediate = {{(DATA_WIDTH-IMM_WIDTH){instr[IMM_MSB]}}, instr[IMM_MSB:IMM_LSB]};

    always_comb begin
        // register-register alu op unless overridden
        rd_address = instr[RD_MSB:RD_LSB];
        rs1_address = instr[RS1_MSB:RS1_LSB];
        rs2_address = instr[RS2_MSB:RS2_LSB];
        alu_op = ALU_ADD;
        use_immediate = 1'b0;
        reg_write_enable = 1'b1;
        reg_input_mux = ALU_OUT;
        case (opcode)
            OP_ADD: alu_op = ALU_ADD;
            OP_SUB: alu_op = ALU_SUB;
            OP_AND: alu_op = ALU_AND;
            OP_OR:  alu_op = ALU_OR;
            OP_XOR: alu_op = ALU_XOR;
            OP_SLL: alu_op = ALU_SLL;
            OP_SRL: alu_op = ALU_SRL;
            OP_ADDI: begin
                // rs1 plus immediate
                use_immediate = 1'b1;
            end
            OP_LI: reg_input_mux = IMMEDIATE;
            OP_LINK: reg_input_mux = PC_PLUS_1;
            default: begin
                // nop: r0 + r0 so the result record carries rd 0, value 0
                rd_address = reg_addr_t'(ZERO_REG);
                rs1_address = reg_addr_t'(ZERO_REG);
                rs2_address = reg_addr_t'(ZERO_REG);
                reg_write_enable = 1'b0;
            end
        endcase
    end

endmodule

/* rtl/isa_pkg.sv */
package isa_pkg;

    // instruction word width
    localparam int INSTR_WIDTH = 32;

    // field positions inside the instruction word
    localparam int OPCODE_MSB = 31;
    localparam int OPCODE_LSB = 28;
    localparam int RD_MSB = 27;
    localparam int RD_LSB = 23;
    localparam int RS1_MSB = 22;
    localparam int RS1_LSB = 18;
    localparam int RS2_MSB = 17;
    localparam int RS2_LSB = 13;
    // immediate is sign-extended to the data width
    localparam int IMM_MSB = 12;
    localparam int IMM_LSB = 0;
    localparam int IMM_WIDTH = IMM_MSB - IMM_LSB + 1;

    typedef logic [INSTR_WIDTH-1:0] instr_t;

    // opcodes 11 to 15 unused, decoded like a nop
    typedef enum logic [3:0] {
        OP_NOP  = 4'd0,
        OP_ADD  = 4'd1,
        OP_SUB  = 4'd2,
        OP_AND  = 4'd3,
        OP_OR   = 4'd4,
        OP_XOR  = 4'd5,
        OP_SLL  = 4'd6,
        OP_SRL  = 4'd7,
        OP_ADDI = 4'd8,
        OP_LI   = 4'd9,
        OP_LINK = 4'd10
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6
    } alu_op_t;

    // writeback source select
    typedef enum logic [1:0] {
        ALU_OUT   = 2'd0,
        IMMEDIATE = 2'd1,
        PC_PLUS_1 = 2'd2
    } reg_input_mux_t;

    // warp state machine
    typedef enum logic [1:0] {
        WARP_IDLE    = 2'd0,
        WARP_REQUEST = 2'd1,
        WARP_UPDATE  = 2'd2
    } warp_state_t;

endpackage

/* rtl/warp_types_pkg.sv */
package warp_types_pkg;

    // data path width
    localparam int DATA_WIDTH = 32;
    // register index width, 32 registers
    localparam int REG_ADDR_WIDTH = 5;
    // warp program counter width
    localparam int PC_WIDTH = 8;
    // wide enough for either credit pool
    localparam int CREDIT_WIDTH = 2;
    // shift amount taken from the low operand bits
    localparam int SHAMT_WIDTH = 5;

    // scalar register file geometry
    localparam int NUM_REGS = 32;
    // hardwired zero register
    localparam int ZERO_REG = 0;
    // warp execution mask lives here
    localparam int EXEC_MASK_REG = 31;

    // instruction buffer depth
    // the producer starts with exactly this many credits
    localparam int INSTR_CREDITS = 2;
    // result credits granted by the consumer at reset
    localparam int RESULT_CREDITS = 2;

    // scalar data word
    typedef logic [DATA_WIDTH-1:0] data_t;
    // register index
    typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
    // program counter, counts retired instructions
    typedef logic [PC_WIDTH-1:0] pc_t;
    // credit and occupancy counts
    typedef logic [CREDIT_WIDTH-1:0] credit_t;

endpackage
